// File: build.f
+incdir+verif
src/vlsu_pkg.sv
src/cq_ptr.sv
src/flow_queue.sv
src/seq_load.sv
src/lane_shuffle.sv
src/vlsu_load_top.sv
verif/tb_vlsu_load.sv

// File: run.sh
#!/usr/bin/env bash
# Compile the VLSU load path testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_vlsu_load \
  --Mdir obj_dir -o sim_vlsu_load > build.log 2>&1 \
  && ./obj_dir/sim_vlsu_load > sim.log 2>&1

grep -qx "Test passed" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// File: src/cq_ptr.sv
// ===================================================================
// Circular queue pointer
// Index that wraps at ENTRIES, with a flag toggled on every wrap
// ===================================================================

`timescale 1ns/100ps
`default_nettype none

module cq_ptr #(
  parameter  int unsigned ENTRIES = 2,
  localparam int unsigned PtrW    = (ENTRIES > 1) ? $clog2(ENTRIES) : 1
) (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  wire logic            inc_i,
  output logic                 flag_o,
  output logic [PtrW-1:0]      value_o
);

  logic at_end;

  assign at_end = (value_o == PtrW'(ENTRIES - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flag_o  <= 1'b0;
      value_o <= '0;
    end else if (inc_i) begin
      if (at_end) begin
        // Wrap around and flip the lap flag
        flag_o  <= ~flag_o;
        value_o <= '0;
      end else begin
        value_o <= value_o + 1'b1;
      end
    end
  end

  a_value_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    value_o < ENTRIES)
    else $error("cq_ptr value out of range");

endmodule

`default_nettype wire

// File: src/flow_queue.sv
// ===================================================================
// Flow-through FIFO
// Valid/ready queue that passes an enqueue straight out when empty
// ===================================================================

`timescale 1ns/100ps
`default_nettype none

module flow_queue #(
  parameter  type         T     = logic,
  parameter  int unsigned DEPTH = 1,
  localparam int unsigned PtrW  = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic enq_valid_i,
  input  wire T     enq_bits_i,
  output logic      enq_ready_o,
  output logic      deq_valid_o,
  output T          deq_bits_o,
  input  wire logic deq_ready_i
);

  T                mem_q [DEPTH];
  logic            enq_flag, deq_flag;
  logic [PtrW-1:0] enq_idx, deq_idx;
  logic            empty, full;
  logic            do_enq, do_deq;

  cq_ptr #(.ENTRIES(DEPTH)) u_enq_ptr (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .inc_i  (do_enq),
    .flag_o (enq_flag),
    .value_o(enq_idx)
  );

  cq_ptr #(.ENTRIES(DEPTH)) u_deq_ptr (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .inc_i  (do_deq),
    .flag_o (deq_flag),
    .value_o(deq_idx)
  );

  assign empty = (enq_idx == deq_idx) && (enq_flag == deq_flag);
  assign full  = (enq_idx == deq_idx) && (enq_flag != deq_flag);

  assign enq_ready_o = !full;
  assign deq_valid_o = !empty || enq_valid_i;
  assign deq_bits_o  = empty ? enq_bits_i : mem_q[deq_idx];

  // A same-cycle pass-through never touches storage
  assign do_enq = enq_valid_i && enq_ready_o && !(empty && deq_ready_i);
  assign do_deq = deq_ready_i && !empty;

  always_ff @(posedge clk_i) begin
    if (do_enq) begin
      mem_q[enq_idx] <= enq_bits_i;
    end
  end

  a_no_deq_when_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    deq_ready_i |-> deq_valid_o)
    else $error("flow_queue dequeue while empty");

endmodule

`default_nettype wire

// File: src/lane_shuffle.sv
// ===================================================================
// Lane shuffle stage
// Registers one staging buffer spread element-wise over the lanes
// ===================================================================

`timescale 1ns/100ps
`default_nettype none

module lane_shuffle import vlsu_pkg::*; #(
  parameter  int unsigned NrLanes   = 2,
  localparam int unsigned BufNb     = NrLanes * LaneWidth / 4,
  localparam int unsigned BufBytes  = BufNb / 2,
  localparam int unsigned LaneBytes = LaneWidth / 8
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         buf_valid_i,
  input  wire logic [BufNb*4-1:0]           buf_nb_i,
  input  wire logic [BufNb-1:0]             buf_en_i,
  input  wire eew_e                         buf_eew_i,
  output logic                              buf_ready_o,
  output logic                              lane_valid_o,
  output logic [NrLanes*LaneWidth-1:0]      lane_data_o,
  output logic [NrLanes*LaneBytes-1:0]      lane_be_o,
  input  wire logic                         lane_ready_i
);

  logic [NrLanes*LaneWidth-1:0] shuf_data;
  logic [NrLanes*LaneBytes-1:0] shuf_be;
  logic                         load;

  // Element k goes to lane k mod NrLanes at slot k div NrLanes
  function automatic int unsigned dest_byte(input int unsigned b, input int unsigned w);
    int unsigned k;
    k = b / w;
    return (k % NrLanes) * LaneBytes + (k / NrLanes) * w + (b % w);
  endfunction

  always_comb begin
    int unsigned d;
    shuf_data = '0;
    shuf_be   = '0;
    for (int unsigned b = 0; b < BufBytes; b++) begin
      case (buf_eew_i)
        EW16:    d = dest_byte(b, 2);
        EW32:    d = dest_byte(b, 4);
        default: d = dest_byte(b, 1);
      endcase
      shuf_data[d*8 +: 8] = buf_nb_i[b*8 +: 8];
      // Either nibble present marks the byte
      shuf_be[d] = buf_en_i[2*b] | buf_en_i[2*b+1];
    end
  end

  // Take a new buffer when empty or when the held one leaves
  assign buf_ready_o = !lane_valid_o || lane_ready_i;
  assign load        = buf_valid_i && buf_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lane_valid_o <= 1'b0;
    end else if (buf_ready_o) begin
      lane_valid_o <= buf_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      lane_data_o <= shuf_data;
      lane_be_o   <= shuf_be;
    end
  end

endmodule

`default_nettype wire

// File: src/seq_load.sv
// ===================================================================
// Sequential load controller
// Packs trimmed R beats nibble by nibble into a ping-pong staging
// buffer and hands full or final buffers to the shuffle stage
// ===================================================================

`timescale 1ns/100ps
`default_nettype none

module seq_load import vlsu_pkg::*; #(
  parameter  int unsigned NrLanes      = 2,
  parameter  int unsigned AxiDataWidth = 32,
  localparam int unsigned BusNb        = AxiDataWidth / 4,
  localparam int unsigned BusNbW       = $clog2(BusNb),
  localparam int unsigned BufNb        = NrLanes * LaneWidth / 4,
  localparam int unsigned BufPtrW      = $clog2(BufNb)
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // R channel
  input  wire logic                    r_valid_i,
  input  wire logic [AxiDataWidth-1:0] r_data_i,
  output logic                         r_ready_o,
  // Transaction control, one entry per beat
  input  wire logic                    txn_valid_i,
  input  wire logic                    txn_is_head_i,
  input  wire logic [BusNbW-1:0]       txn_addr_off_i,
  input  wire logic [BusNbW:0]         txn_lbn_i,
  input  wire logic [BeatCntWidth-1:0] txn_rmn_beat_i,
  input  wire logic                    txn_final_i,
  output logic                         txn_ready_o,
  // Request metadata
  input  wire logic                    info_valid_i,
  input  wire seq_info_t               info_i,
  output logic                         info_ready_o,
  // Staging buffer out
  output logic                         buf_valid_o,
  output logic [BufNb*4-1:0]           buf_nb_o,
  output logic [BufNb-1:0]             buf_en_o,
  output eew_e                         buf_eew_o,
  input  wire logic                    buf_ready_i
);

  // Wide enough for both bus and buffer nibble counts
  localparam int unsigned CntW = ((BusNbW > BufPtrW) ? BusNbW : BufPtrW) + 1;

  typedef enum logic {
    S_IDLE,
    S_SERIAL
  } state_e;

  state_e               state_q, state_d;
  logic [BusNbW-1:0]    bus_cnt_q, bus_cnt_d;
  logic [BufPtrW-1:0]   buf_ptr_q, buf_ptr_d;
  eew_e                 eew_q, eew_d;

  // Ping-pong staging entries
  logic [BufNb*4-1:0]   nb_q [2];
  logic [BufNb*4-1:0]   nb_d [2];
  logic [BufNb-1:0]     en_q [2];
  logic [BufNb-1:0]     en_d [2];
  eew_e                 beew_q [2];
  eew_e                 beew_d [2];

  logic                 enq_flag, deq_flag;
  logic                 enq_idx, deq_idx;
  logic                 buf_enq, buf_deq;
  logic                 buf_empty, buf_full;

  logic                 is_last, do_cmt, overflow, beat_ack;
  logic [CntW-1:0]      lower_nb, upper_nb, bus_nb, free_nb, n_cmt;

  cq_ptr #(.ENTRIES(2)) u_enq_ptr (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .inc_i  (buf_enq),
    .flag_o (enq_flag),
    .value_o(enq_idx)
  );

  cq_ptr #(.ENTRIES(2)) u_deq_ptr (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .inc_i  (buf_deq),
    .flag_o (deq_flag),
    .value_o(deq_idx)
  );

  assign buf_empty = (enq_idx == deq_idx) && (enq_flag == deq_flag);
  assign buf_full  = (enq_idx == deq_idx) && (enq_flag != deq_flag);

  // ================================================================
  // Beat trimming and free space
  // ================================================================
  assign is_last  = txn_final_i && (txn_rmn_beat_i == '0);
  assign lower_nb = txn_is_head_i ? CntW'(txn_addr_off_i) : '0;
  assign upper_nb = is_last ? CntW'(txn_lbn_i) : CntW'(BusNb);
  // Nibbles of this beat not yet committed
  assign bus_nb   = upper_nb - lower_nb - CntW'(bus_cnt_q);
  assign free_nb  = CntW'(BufNb) - CntW'(buf_ptr_q);
  assign overflow = bus_nb > free_nb;
  assign n_cmt    = overflow ? free_nb : bus_nb;
  assign do_cmt   = (state_q == S_SERIAL) && r_valid_i && txn_valid_i && !buf_full;

  assign r_ready_o   = beat_ack;
  assign txn_ready_o = beat_ack;

  // ================================================================
  // FSM and buffer update
  // ================================================================
  always_comb begin
    int unsigned lo;
    int unsigned hi;
    int unsigned src;
    state_d      = state_q;
    bus_cnt_d    = bus_cnt_q;
    buf_ptr_d    = buf_ptr_q;
    eew_d        = eew_q;
    nb_d         = nb_q;
    en_d         = en_q;
    beew_d       = beew_q;
    info_ready_o = 1'b0;
    beat_ack     = 1'b0;
    buf_enq      = 1'b0;
    lo           = buf_ptr_q;
    hi           = lo + n_cmt;

    case (state_q)
      S_IDLE: begin
        // Start a request once a beat and its metadata are both here
        if (txn_valid_i && info_valid_i) begin
          info_ready_o = 1'b1;
          buf_ptr_d    = info_i.nb_ptr[BufPtrW-1:0];
          eew_d        = info_i.eew;
          bus_cnt_d    = '0;
          state_d      = S_SERIAL;
        end
      end
      S_SERIAL: begin
        if (do_cmt) begin
          if (overflow) begin
            // Fill the rest of this entry, keep the beat for the next one
            bus_cnt_d = bus_cnt_q + BusNbW'(free_nb);
            buf_ptr_d = '0;
            buf_enq   = 1'b1;
          end else begin
            beat_ack  = 1'b1;
            bus_cnt_d = '0;
            buf_ptr_d = buf_ptr_q + BufPtrW'(n_cmt);
            if ((n_cmt == free_nb) || is_last) begin
              buf_enq   = 1'b1;
              buf_ptr_d = '0;
            end
            if (is_last) begin
              state_d = S_IDLE;
            end
          end
        end
      end
      default: state_d = S_IDLE;
    endcase

    // Dequeued entry never aliases the one being filled
    if (buf_deq) begin
      nb_d[deq_idx] = '0;
      en_d[deq_idx] = '0;
    end

    if (do_cmt) begin
      beew_d[enq_idx] = eew_q;
      for (int unsigned i = 0; i < BufNb; i++) begin
        if ((i >= lo) && (i < hi)) begin
          src = i - lo + lower_nb + bus_cnt_q;
          nb_d[enq_idx][i*4 +: 4] = r_data_i[src*4 +: 4];
          en_d[enq_idx][i]        = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= S_IDLE;
      bus_cnt_q <= '0;
      buf_ptr_q <= '0;
      eew_q     <= EW8;
      nb_q      <= '{default: '0};
      en_q      <= '{default: '0};
      beew_q    <= '{default: EW8};
    end else begin
      state_q   <= state_d;
      bus_cnt_q <= bus_cnt_d;
      buf_ptr_q <= buf_ptr_d;
      eew_q     <= eew_d;
      nb_q      <= nb_d;
      en_q      <= en_d;
      beew_q    <= beew_d;
    end
  end

  // ================================================================
  // Buffer dequeue side
  // ================================================================
  assign buf_valid_o = !buf_empty;
  assign buf_nb_o    = nb_q[deq_idx];
  assign buf_en_o    = en_q[deq_idx];
  assign buf_eew_o   = beew_q[deq_idx];
  assign buf_deq     = buf_valid_o && buf_ready_i;

  // Trim bounds from the txn channel must describe a real range
  a_beat_in_bus: assert property (@(posedge clk_i) disable iff (!rst_ni)
    do_cmt |-> (lower_nb + CntW'(bus_cnt_q) <= upper_nb) && (bus_nb <= CntW'(BusNb)))
    else $error("seq_load beat range exceeds bus width");

  a_free_in_buf: assert property (@(posedge clk_i) disable iff (!rst_ni)
    free_nb <= CntW'(BufNb))
    else $error("seq_load free space exceeds buffer size");

endmodule

`default_nettype wire

// File: src/vlsu_load_top.sv
// ===================================================================
// VLSU load data path top
// Metadata queue, sequential loader and lane shuffle stage
// ===================================================================

`timescale 1ns/100ps
`default_nettype none

module vlsu_load_top import vlsu_pkg::*; #(
  parameter  int unsigned NrLanes      = 2,
  parameter  int unsigned AxiDataWidth = 32,
  localparam int unsigned BusNbW       = $clog2(AxiDataWidth / 4),
  localparam int unsigned BufNb        = NrLanes * LaneWidth / 4
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  // Metadata
  input  wire logic                         meta_valid_i,
  output logic                              meta_ready_o,
  input  wire logic [NbPtrWidth-1:0]        meta_nb_ptr_i,
  input  wire eew_e                         meta_eew_i,
  // R channel
  input  wire logic                         r_valid_i,
  output logic                              r_ready_o,
  input  wire logic [AxiDataWidth-1:0]      r_data_i,
  // Transaction control
  input  wire logic                         txn_valid_i,
  output logic                              txn_ready_o,
  input  wire logic                         txn_is_head_i,
  input  wire logic [BusNbW-1:0]            txn_addr_off_i,
  input  wire logic [BusNbW:0]              txn_lbn_i,
  input  wire logic [BeatCntWidth-1:0]      txn_rmn_beat_i,
  input  wire logic                         txn_final_i,
  // Lane output
  output logic                              lane_valid_o,
  input  wire logic                         lane_ready_i,
  output logic [NrLanes*LaneWidth-1:0]      lane_data_o,
  output logic [NrLanes*LaneWidth/8-1:0]    lane_be_o
);

  seq_info_t          meta_bits, info_bits;
  logic               info_valid, info_ready;
  logic               buf_valid, buf_ready;
  logic [BufNb*4-1:0] buf_nb;
  logic [BufNb-1:0]   buf_en;
  eew_e               buf_eew;

  assign meta_bits = '{nb_ptr: meta_nb_ptr_i, eew: meta_eew_i};

  flow_queue #(.T(seq_info_t), .DEPTH(1)) u_meta_q (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .enq_valid_i(meta_valid_i),
    .enq_bits_i (meta_bits),
    .enq_ready_o(meta_ready_o),
    .deq_valid_o(info_valid),
    .deq_bits_o (info_bits),
    .deq_ready_i(info_ready)
  );

  seq_load #(.NrLanes(NrLanes), .AxiDataWidth(AxiDataWidth)) u_seq_load (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .r_valid_i     (r_valid_i),
    .r_data_i      (r_data_i),
    .r_ready_o     (r_ready_o),
    .txn_valid_i   (txn_valid_i),
    .txn_is_head_i (txn_is_head_i),
    .txn_addr_off_i(txn_addr_off_i),
    .txn_lbn_i     (txn_lbn_i),
    .txn_rmn_beat_i(txn_rmn_beat_i),
    .txn_final_i   (txn_final_i),
    .txn_ready_o   (txn_ready_o),
    .info_valid_i  (info_valid),
    .info_i        (info_bits),
    .info_ready_o  (info_ready),
    .buf_valid_o   (buf_valid),
    .buf_nb_o      (buf_nb),
    .buf_en_o      (buf_en),
    .buf_eew_o     (buf_eew),
    .buf_ready_i   (buf_ready)
  );

  lane_shuffle #(.NrLanes(NrLanes)) u_lane_shuffle (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .buf_valid_i (buf_valid),
    .buf_nb_i    (buf_nb),
    .buf_en_i    (buf_en),
    .buf_eew_i   (buf_eew),
    .buf_ready_o (buf_ready),
    .lane_valid_o(lane_valid_o),
    .lane_data_o (lane_data_o),
    .lane_be_o   (lane_be_o),
    .lane_ready_i(lane_ready_i)
  );

endmodule

`default_nettype wire

// File: src/vlsu_pkg.sv
// ===================================================================
// VLSU load path definitions
// Lane and buffer sizing, element width codes and request metadata
// ===================================================================

`default_nettype none

package vlsu_pkg;

  // Bits held per lane in one staging buffer
  localparam int unsigned LaneWidth = 32;

  // Largest lane count the metadata pointer can address
  localparam int unsigned MaxNrLanes    = 8;
  localparam int unsigned MaxBufNibbles = MaxNrLanes * LaneWidth / 4;
  localparam int unsigned NbPtrWidth    = $clog2(MaxBufNibbles);

  // Width of the remaining-beat count on the txn channel
  localparam int unsigned BeatCntWidth = 8;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2
  } eew_e;

  // Per-request metadata, popped once at the start of a load
  typedef struct packed {
    logic [NbPtrWidth-1:0] nb_ptr;
    eew_e                  eew;
  } seq_info_t;

endpackage

`default_nettype wire

// File: verif/tb_vlsu_load_tasks.svh
// ======================================================================
// VLSU load testbench tasks
// Stimulus drivers, reference model and lane output checks
// ======================================================================

`ifndef TB_VLSU_LOAD_TASKS_SVH
`define TB_VLSU_LOAD_TASKS_SVH

task automatic fill_random_beats(input int unsigned n);
  for (int unsigned i = 0; i < n; i++) begin
    beat_data[i] = $urandom;
  end
endtask

// Element k of w bytes lands in lane k mod NrLanes at slot k div NrLanes
task automatic expect_buffer(input logic [BufNb*4-1:0] nbuf, input logic [BufNb-1:0] nen,
                             input eew_e eew);
  logic [NrLanes*LaneWidth-1:0]   data;
  logic [NrLanes*LaneWidth/8-1:0] be;
  int unsigned                    w;
  int unsigned                    src;
  int unsigned                    dst;
  data = '0;
  be   = '0;
  w    = 1 << int'(eew);
  for (int unsigned k = 0; k < BufNb / (2 * w); k++) begin
    for (int unsigned i = 0; i < w; i++) begin
      src              = k * w + i;
      dst              = (k % NrLanes) * (LaneWidth / 8) + (k / NrLanes) * w + i;
      data[dst*8 +: 8] = nbuf[src*8 +: 8];
      be[dst]          = nen[2*src] | nen[2*src+1];
    end
  end
  exp_data_q.push_back(data);
  exp_be_q.push_back(be);
endtask

// Trimmed nibbles continue across beats from nb_ptr on
task automatic model_request(input int unsigned nb_ptr, input eew_e eew, input int unsigned n,
                             input int unsigned head_off, input int unsigned last_lbn);
  logic [BufNb*4-1:0] nbuf;
  logic [BufNb-1:0]   nen;
  int unsigned        pos;
  int unsigned        lo;
  int unsigned        hi;
  nbuf = '0;
  nen  = '0;
  pos  = nb_ptr;
  for (int unsigned b = 0; b < n; b++) begin
    lo = (b == 0) ? head_off : 0;
    hi = (b == n - 1) ? last_lbn : BusNb;
    for (int unsigned j = lo; j < hi; j++) begin
      nbuf[pos*4 +: 4] = beat_data[b][j*4 +: 4];
      nen[pos]         = 1'b1;
      pos++;
      if (pos == BufNb) begin
        expect_buffer(nbuf, nen, eew);
        nbuf = '0;
        nen  = '0;
        pos  = 0;
      end
    end
  end
  // Final beat closes a partly filled buffer
  if (nen != '0) begin
    expect_buffer(nbuf, nen, eew);
  end
endtask

task automatic push_meta(input int unsigned nb_ptr, input eew_e eew);
  int unsigned waited;
  waited = 0;
  @(posedge clk_i);
  meta_valid_i  <= 1'b1;
  meta_nb_ptr_i <= NbPtrWidth'(nb_ptr);
  meta_eew_i    <= eew;
  @(negedge clk_i);
  while (!meta_ready_o) begin
    waited++;
    if (waited > WaitLimit) begin
      abort_run("Timeout while waiting for the metadata queue to accept a request");
    end
    @(negedge clk_i);
  end
  @(posedge clk_i);
  meta_valid_i <= 1'b0;
endtask

// One burst, so txn_final_i stays high and the beat count runs down
task automatic drive_beats(input int unsigned n, input int unsigned head_off,
                           input int unsigned last_lbn);
  int unsigned waited;
  for (int unsigned b = 0; b < n; b++) begin
    r_valid_i      <= 1'b1;
    r_data_i       <= beat_data[b];
    txn_valid_i    <= 1'b1;
    txn_is_head_i  <= (b == 0);
    txn_addr_off_i <= BusNbW'(head_off);
    txn_lbn_i      <= (BusNbW + 1)'(last_lbn);
    txn_rmn_beat_i <= BeatCntWidth'(n - 1 - b);
    txn_final_i    <= 1'b1;
    waited = 0;
    @(negedge clk_i);
    while (!r_ready_o) begin
      // R and txn are refused together
      assert (!txn_ready_o)
        else abort_run($sformatf("error %0t txn_ready_o got %b expected 0", $time,
                                 txn_ready_o));
      waited++;
      if (waited > WaitLimit) begin
        abort_run("Timeout while waiting for an R beat to be accepted");
      end
      @(negedge clk_i);
    end
    assert (txn_ready_o)
      else abort_run($sformatf("error %0t txn_ready_o got %b expected 1", $time,
                               txn_ready_o));
    @(posedge clk_i);
  end
  r_valid_i     <= 1'b0;
  txn_valid_i   <= 1'b0;
  txn_is_head_i <= 1'b0;
  txn_final_i   <= 1'b0;
endtask

task automatic check_lane_outputs();
  logic [NrLanes*LaneWidth-1:0] mask;
  int unsigned                  waited;
  while (exp_data_q.size() > 0) begin
    waited = 0;
    @(negedge clk_i);
    while (!(lane_valid_o && lane_ready_i)) begin
      waited++;
      if (waited > WaitLimit) begin
        abort_run("Timeout while waiting for a lane output");
      end
      @(negedge clk_i);
    end
    // Bytes without an enable carry no data
    for (int unsigned b = 0; b < NrLanes * LaneWidth / 8; b++) begin
      mask[b*8 +: 8] = {8{exp_be_q[0][b]}};
    end
    assert (lane_be_o == exp_be_q[0])
      else abort_run($sformatf("error %0t lane_be_o got %h expected %h", $time,
                               lane_be_o, exp_be_q[0]));
    assert ((lane_data_o & mask) == (exp_data_q[0] & mask))
      else abort_run($sformatf("error %0t lane_data_o got %h expected %h", $time,
                               lane_data_o & mask, exp_data_q[0] & mask));
    void'(exp_data_q.pop_front());
    void'(exp_be_q.pop_front());
    checks_done++;
  end
endtask

// R beat offered but refused while the lane output is held
task automatic wait_for_stall();
  int unsigned waited;
  int unsigned stalled;
  waited  = 0;
  stalled = 0;
  while (stalled < 8) begin
    @(negedge clk_i);
    if (r_valid_i && !r_ready_o && lane_valid_o) begin
      stalled++;
    end else begin
      stalled = 0;
    end
    waited++;
    if (waited > WaitLimit) begin
      abort_run("Timeout because r_ready_o never dropped while the lanes were held");
    end
  end
endtask

task automatic check_idle_outputs();
  assert (!lane_valid_o)
    else abort_run($sformatf("error %0t lane_valid_o got %b expected 0", $time, lane_valid_o));
  assert (!r_ready_o)
    else abort_run($sformatf("error %0t r_ready_o got %b expected 0", $time, r_ready_o));
  assert (!txn_ready_o)
    else abort_run($sformatf("error %0t txn_ready_o got %b expected 0", $time, txn_ready_o));
endtask

task automatic run_request(input int unsigned nb_ptr, input eew_e eew, input int unsigned n,
                           input int unsigned head_off, input int unsigned last_lbn);
  model_request(nb_ptr, eew, n, head_off, last_lbn);
  fork
    begin
      push_meta(nb_ptr, eew);
      drive_beats(n, head_off, last_lbn);
    end
    check_lane_outputs();
  join
endtask

`endif

// File: verif/tb_vlsu_load.sv
// ======================================================================
// VLSU load path testbench
// Clock, reset, DUT and the sequence of directed tests
// ======================================================================

`timescale 1ns/100ps
`default_nettype none

module tb_vlsu_load import vlsu_pkg::*; ();

  localparam int unsigned NrLanes      = 2;
  localparam int unsigned AxiDataWidth = 32;
  localparam int unsigned BusNb        = AxiDataWidth / 4;
  localparam int unsigned BusNbW       = $clog2(BusNb);
  localparam int unsigned BufNb        = NrLanes * LaneWidth / 4;
  localparam int unsigned WaitLimit    = 200;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           meta_valid_i;
  logic                           meta_ready_o;
  logic [NbPtrWidth-1:0]          meta_nb_ptr_i;
  eew_e                           meta_eew_i;
  logic                           r_valid_i;
  logic                           r_ready_o;
  logic [AxiDataWidth-1:0]        r_data_i;
  logic                           txn_valid_i;
  logic                           txn_ready_o;
  logic                           txn_is_head_i;
  logic [BusNbW-1:0]              txn_addr_off_i;
  logic [BusNbW:0]                txn_lbn_i;
  logic [BeatCntWidth-1:0]        txn_rmn_beat_i;
  logic                           txn_final_i;
  logic                           lane_valid_o;
  logic                           lane_ready_i;
  logic [NrLanes*LaneWidth-1:0]   lane_data_o;
  logic [NrLanes*LaneWidth/8-1:0] lane_be_o;

  // Beat payloads of the current request and the expected lane outputs
  logic [AxiDataWidth-1:0]        beat_data [8];
  logic [NrLanes*LaneWidth-1:0]   exp_data_q [$];
  logic [NrLanes*LaneWidth/8-1:0] exp_be_q [$];
  int unsigned                    checks_done;

  vlsu_load_top #(.NrLanes(NrLanes), .AxiDataWidth(AxiDataWidth)) u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .meta_valid_i  (meta_valid_i),
    .meta_ready_o  (meta_ready_o),
    .meta_nb_ptr_i (meta_nb_ptr_i),
    .meta_eew_i    (meta_eew_i),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .r_data_i      (r_data_i),
    .txn_valid_i   (txn_valid_i),
    .txn_ready_o   (txn_ready_o),
    .txn_is_head_i (txn_is_head_i),
    .txn_addr_off_i(txn_addr_off_i),
    .txn_lbn_i     (txn_lbn_i),
    .txn_rmn_beat_i(txn_rmn_beat_i),
    .txn_final_i   (txn_final_i),
    .lane_valid_o  (lane_valid_o),
    .lane_ready_i  (lane_ready_i),
    .lane_data_o   (lane_data_o),
    .lane_be_o     (lane_be_o)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
  endtask

  `include "tb_vlsu_load_tasks.svh"

  // ====================================================================
  // Directed tests
  // ====================================================================
  // A beat without metadata is offered during and after reset
  task automatic reset_state_check();
    @(posedge clk_i);
    r_valid_i   <= 1'b1;
    txn_valid_i <= 1'b1;
    for (int unsigned i = 0; i < 16; i++) begin
      @(negedge clk_i);
      check_idle_outputs();
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      check_idle_outputs();
      assert (meta_ready_o)
        else abort_run($sformatf("error %0t meta_ready_o got %b expected 1", $time,
                                 meta_ready_o));
    end
    @(posedge clk_i);
    r_valid_i   <= 1'b0;
    txn_valid_i <= 1'b0;
  endtask

  // Two full beats fill exactly one buffer
  task automatic aligned_single();
    fill_random_beats(2);
    run_request(0, EW8, 2, 0, BusNb);
  endtask

  task automatic trim_head_tail();
    fill_random_beats(2);
    run_request(2, EW8, 2, 3, 5);
  endtask

  // Odd start pointer makes the second beat overflow into the next buffer
  task automatic split_across_buffers();
    fill_random_beats(2);
    run_request(5, EW8, 2, 0, BusNb);
  endtask

  task automatic eew_placement();
    fill_random_beats(2);
    run_request(0, EW16, 2, 0, BusNb);
    run_request(0, EW32, 2, 0, BusNb);
  endtask

  // Four buffers against a stalled output where at most three fit in flight
  task automatic hold_lanes();
    fill_random_beats(8);
    model_request(0, EW8, 8, 0, BusNb);
    @(posedge clk_i);
    lane_ready_i <= 1'b0;
    fork
      begin
        push_meta(0, EW8);
        drive_beats(8, 0, BusNb);
      end
      begin
        wait_for_stall();
        @(posedge clk_i);
        lane_ready_i <= 1'b1;
        check_lane_outputs();
      end
    join
  endtask

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    void'($urandom(32'h0d91e513));
    rst_ni         = 1'b0;
    meta_valid_i   = 1'b0;
    meta_nb_ptr_i  = '0;
    meta_eew_i     = EW8;
    r_valid_i      = 1'b0;
    r_data_i       = '0;
    txn_valid_i    = 1'b0;
    txn_is_head_i  = 1'b0;
    txn_addr_off_i = '0;
    txn_lbn_i      = '0;
    txn_rmn_beat_i = '0;
    txn_final_i    = 1'b0;
    lane_ready_i   = 1'b1;
    checks_done    = 0;

    reset_state_check();
    aligned_single();
    trim_head_tail();
    split_across_buffers();
    eew_placement();
    hold_lanes();

    if (checks_done > 0) begin
      $display("Test passed");
      $finish;
    end else begin
      abort_run("No lane output was compared");
    end
  end

endmodule

`default_nettype wire
